// File: axi_lite_slave/axi_lite_slave_read.sv
`timescale 1ns/1ps

module axi_lite_slave_read (
	input logic clk,
	input logic rst_n,

	input logic [axi_lite_pkg::DATA_WIDTH-1:0] reg_vals [regmap_pkg::NUM_REGS],

	input axi_lite_pkg::axi_ar_t ar,
	input logic ar_valid,
	output logic ar_ready,

	output axi_lite_pkg::axi_r_t r,
	output logic r_valid,
	input logic r_ready
);

	typedef enum logic {
		IDLE,
		VALID
	} rd_state_e;

	rd_state_e state;

	regmap_pkg::reg_rd_t rd_sel;
	logic rd_ok;
	logic ar_beat;

	assign rd_sel = '{idx: ar.addr[axi_lite_pkg::ADDR_WIDTH-1:2]};
	assign rd_ok = regmap_pkg::idx_in_range(rd_sel.idx);

	assign ar_ready = (state == IDLE);
	assign r_valid = (state == VALID);
	assign ar_beat = ar_valid && ar_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (ar_valid) begin
						state <= VALID;
					end
				end

				VALID: begin
					if (r_ready) begin
						state <= IDLE; // R beat accepted
					end
				end

				default: state <= IDLE;
			endcase
		end
	end

	// The R payload is captured once and held until the master takes it
	always_ff @(posedge clk) begin
		if (ar_beat) begin
			if (rd_ok) begin
				r <= '{
					data: reg_vals[rd_sel.idx[regmap_pkg::SEL_WIDTH-1:0]],
					resp: axi_lite_pkg::RESP_OKAY
				};
			end else begin
				r <= '{data: '0, resp: axi_lite_pkg::RESP_SLVERR}; // Unmapped reads return zero
			end
		end
	end

endmodule

// File: axi_lite_slave/axi_lite_slave_write.sv
`timescale 1ns/1ps

module axi_lite_slave_write (
	input logic clk,
	input logic rst_n,

	input logic [axi_lite_pkg::DATA_WIDTH-1:0] reg_vals [regmap_pkg::NUM_REGS],
	output regmap_pkg::reg_wr_t reg_wr,

	input axi_lite_pkg::axi_aw_t aw,
	input logic aw_valid,
	output logic aw_ready,

	input axi_lite_pkg::axi_w_t w,
	input logic w_valid,
	output logic w_ready,

	output axi_lite_pkg::axi_b_t b,
	output logic b_valid,
	input logic b_ready
);

	typedef enum logic [1:0] {
		WAIT_ADDR,
		WAIT_DATA,
		RESPONSE
	} wr_state_e;

	wr_state_e state, state_next;

	regmap_pkg::reg_idx_t idx, idx_next;
	axi_lite_pkg::axi_b_t b_next;
	logic addr_ok;

	logic wr_en, wr_en_next;
	logic [axi_lite_pkg::DATA_WIDTH-1:0] wr_value, wr_value_next;
	regmap_pkg::reg_idx_t wr_idx, wr_idx_next;

	logic [axi_lite_pkg::DATA_WIDTH-1:0] strb_mask;
	logic [axi_lite_pkg::DATA_WIDTH-1:0] cur_value;
	logic [axi_lite_pkg::DATA_WIDTH-1:0] merged;

	assign addr_ok = (b.resp == axi_lite_pkg::RESP_OKAY); // Range result kept from the AW beat

	always_comb begin
		for (int i = 0; i < axi_lite_pkg::STRB_WIDTH; i++) begin
			strb_mask[8*i +: 8] = {8{w.strb[i]}};
		end
	end

	// Out-of-range indices alias a real entry here but are never written
	assign cur_value = reg_vals[idx[regmap_pkg::SEL_WIDTH-1:0]];
	assign merged = (cur_value & ~strb_mask) | (w.data & strb_mask);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= WAIT_ADDR;
			b <= '{resp: axi_lite_pkg::RESP_OKAY};
			wr_en <= 1'b0;
		end else begin
			state <= state_next;
			b <= b_next;
			wr_en <= wr_en_next;
		end
	end

	always_ff @(posedge clk) begin
		idx <= idx_next;
		wr_idx <= wr_idx_next;
		wr_value <= wr_value_next;
	end

	assign reg_wr = '{idx: wr_idx, value: wr_value, en: wr_en};

	always_comb begin
		state_next = state;
		idx_next = idx;
		b_next = b;
		wr_en_next = 1'b0; // Enable lasts a single cycle
		wr_idx_next = wr_idx;
		wr_value_next = wr_value;

		aw_ready = 1'b0;
		w_ready = 1'b0;
		b_valid = 1'b0;

		case (state)
			WAIT_ADDR: begin
				aw_ready = 1'b1;
				if (aw_valid) begin
					state_next = WAIT_DATA;
					idx_next = aw.addr[axi_lite_pkg::ADDR_WIDTH-1:2];
					if (regmap_pkg::idx_in_range(aw.addr[axi_lite_pkg::ADDR_WIDTH-1:2])) begin
						b_next.resp = axi_lite_pkg::RESP_OKAY;
					end else begin
						b_next.resp = axi_lite_pkg::RESP_SLVERR;
					end
				end
			end

			WAIT_DATA: begin
				w_ready = 1'b1;
				if (w_valid) begin
					state_next = RESPONSE;
					if (addr_ok) begin
						wr_en_next = 1'b1;
						wr_idx_next = idx;
						wr_value_next = merged;
					end
				end
			end

			RESPONSE: begin
				b_valid = 1'b1;
				if (b_ready) begin
					state_next = WAIT_ADDR;
					b_next.resp = axi_lite_pkg::RESP_OKAY;
				end
			end

			default: state_next = WAIT_ADDR;
		endcase
	end

endmodule

// File: common/axi_lite_pkg.sv
package axi_lite_pkg;

	localparam int ADDR_WIDTH = 7;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	localparam int PROT_WIDTH = 3;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [PROT_WIDTH-1:0] prot; // Accepted but not interpreted
	} axi_aw_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [STRB_WIDTH-1:0] strb;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [PROT_WIDTH-1:0] prot; // Accepted but not interpreted
	} axi_ar_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [1:0] resp;
	} axi_r_t;

endpackage

// File: common/regmap_pkg.sv
package regmap_pkg;

	localparam int NUM_REGS = 4;
	localparam int IDX_WIDTH = axi_lite_pkg::ADDR_WIDTH - 2; // Byte address without the low two bits
	localparam int SEL_WIDTH = $clog2(NUM_REGS);
	localparam int ID_IDX = NUM_REGS - 1; // Last register is the read-only ID word

	localparam logic [axi_lite_pkg::DATA_WIDTH-1:0] ID_VALUE = 32'h5A17_0104;

	// Entry 0 is the rightmost word
	localparam logic [NUM_REGS-2:0][axi_lite_pkg::DATA_WIDTH-1:0] RESET_VALUES = {
		32'hCAFE_0000, // Register 2
		32'h0000_00FF, // Register 1
		32'h0000_0000  // Register 0
	};

	typedef logic [IDX_WIDTH-1:0] reg_idx_t;

	typedef struct packed {
		reg_idx_t idx;
		logic [axi_lite_pkg::DATA_WIDTH-1:0] value;
		logic en;
	} reg_wr_t;

	typedef struct packed {
		reg_idx_t idx;
	} reg_rd_t;

	function automatic logic idx_in_range(reg_idx_t idx);
		return idx < reg_idx_t'(NUM_REGS);
	endfunction

endpackage

// File: design/axi_lite_regs_top.sv
`timescale 1ns/1ps

module axi_lite_regs_top (
	input logic clk,
	input logic rst_n,

	input axi_lite_pkg::axi_aw_t aw,
	input logic aw_valid,
	output logic aw_ready,

	input axi_lite_pkg::axi_w_t w,
	input logic w_valid,
	output logic w_ready,

	output axi_lite_pkg::axi_b_t b,
	output logic b_valid,
	input logic b_ready,

	input axi_lite_pkg::axi_ar_t ar,
	input logic ar_valid,
	output logic ar_ready,

	output axi_lite_pkg::axi_r_t r,
	output logic r_valid,
	input logic r_ready
);

	logic [axi_lite_pkg::DATA_WIDTH-1:0] reg_vals [regmap_pkg::NUM_REGS];
	regmap_pkg::reg_wr_t reg_wr;

	axi_lite_slave_write u_write (
		.clk      (clk),
		.rst_n    (rst_n),
		.reg_vals (reg_vals),
		.reg_wr   (reg_wr),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.b        (b),
		.b_valid  (b_valid),
		.b_ready  (b_ready)
	);

	axi_lite_slave_read u_read (
		.clk      (clk),
		.rst_n    (rst_n),
		.reg_vals (reg_vals),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready)
	);

	reg_bank u_bank (
		.clk      (clk),
		.rst_n    (rst_n),
		.reg_wr   (reg_wr),
		.reg_vals (reg_vals)
	);

endmodule

// File: design/reg_bank.sv
`timescale 1ns/1ps

module reg_bank (
	input logic clk,
	input logic rst_n,

	input regmap_pkg::reg_wr_t reg_wr,
	output logic [axi_lite_pkg::DATA_WIDTH-1:0] reg_vals [regmap_pkg::NUM_REGS]
);

	// Only the writable registers have storage
	logic [axi_lite_pkg::DATA_WIDTH-1:0] regs [regmap_pkg::ID_IDX];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < regmap_pkg::ID_IDX; i++) begin
				regs[i] <= regmap_pkg::RESET_VALUES[i];
			end
		end else if (reg_wr.en) begin
			for (int i = 0; i < regmap_pkg::ID_IDX; i++) begin
				if (reg_wr.idx == regmap_pkg::reg_idx_t'(i)) begin
					regs[i] <= reg_wr.value;
				end
			end
			// A write to the ID index matches no entry and is dropped
		end
	end

	always_comb begin
		for (int i = 0; i < regmap_pkg::ID_IDX; i++) begin
			reg_vals[i] = regs[i];
		end
		reg_vals[regmap_pkg::ID_IDX] = regmap_pkg::ID_VALUE; // Constant, never stored
	end

endmodule

// File: flist.f
common/axi_lite_pkg.sv
common/regmap_pkg.sv
axi_lite_slave/axi_lite_slave_write.sv
axi_lite_slave/axi_lite_slave_read.sv
design/reg_bank.sv
design/axi_lite_regs_top.sv
verif/axi_lite_regs_sva.sv
verif/axi_lite_regs_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the register block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module axi_lite_regs_tb \
	-f flist.f \
	-o axi_lite_regs_sim

./obj_dir/axi_lite_regs_sim

// File: verif/axi_lite_golden.txt
# W <addr> <data> <strb> <resp>   write, expected B response
# R <addr> <data> <resp>          read, expected R data and response (hex, 0 OKAY, 2 SLVERR)
R 00 00000000 0
R 04 000000ff 0
R 08 cafe0000 0
R 0c 5a170104 0
W 00 12345678 f 0
R 00 12345678 0
W 04 a5a5a5a5 f 0
R 04 a5a5a5a5 0
W 04 00001100 2 0
R 04 a5a511a5 0
W 08 77665544 9 0
R 08 77fe0044 0
W 00 deadbeef 0 0
R 00 12345678 0
W 00 0000ab00 6 0
R 00 1200ab78 0
W 0c ffffffff f 0
R 0c 5a170104 0
W 0e 00000000 f 0
R 0d 5a170104 0
W 10 11111111 f 2
R 10 00000000 2
W 7c 22222222 f 2
R 7c 00000000 2
R 40 00000000 2
R 00 1200ab78 0
R 04 a5a511a5 0
R 08 77fe0044 0
W 01 0000000f 1 0
R 03 1200ab0f 0
W 0b 33000000 8 0
R 08 33fe0044 0
W 05 ffffffff f 0
R 06 ffffffff 0

// File: verif/axi_lite_regs_sva.sv
`timescale 1ns/1ps

module axi_lite_regs_sva (
	input logic clk,
	input logic rst_n,
	input axi_lite_pkg::axi_aw_t aw,
	input logic aw_valid,
	input logic aw_ready,
	input axi_lite_pkg::axi_w_t w,
	input logic w_valid,
	input logic w_ready,
	input axi_lite_pkg::axi_b_t b,
	input logic b_valid,
	input logic b_ready,
	input axi_lite_pkg::axi_ar_t ar,
	input logic ar_valid,
	input logic ar_ready,
	input axi_lite_pkg::axi_r_t r,
	input logic r_valid,
	input logic r_ready
);

	aw_held: assert property (@(posedge clk) disable iff (!rst_n)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else $error("aw_valid or aw changed before aw_ready");

	w_held: assert property (@(posedge clk) disable iff (!rst_n)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else $error("w_valid or w changed before w_ready");

	b_held: assert property (@(posedge clk) disable iff (!rst_n)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else $error("b_valid or b changed before b_ready");

	ar_held: assert property (@(posedge clk) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else $error("ar_valid or ar changed before ar_ready");

	r_held: assert property (@(posedge clk) disable iff (!rst_n)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else $error("r_valid or r changed before r_ready");

	// Checked from the first reset edge on
	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |=> !b_valid && !r_valid)
		else $error("b_valid or r_valid high during reset");

	b_after_w: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(b_valid) |-> $past(w_valid && w_ready))
		else $error("b_valid rose without a preceding W beat");

endmodule

bind axi_lite_regs_top axi_lite_regs_sva u_sva (.*);

// File: verif/axi_lite_regs_tb.sv
`timescale 1ns/1ps

module axi_lite_regs_tb;

	typedef struct packed {
		logic is_write;
		logic [axi_lite_pkg::ADDR_WIDTH-1:0] addr;
		logic [axi_lite_pkg::DATA_WIDTH-1:0] data;
		logic [axi_lite_pkg::STRB_WIDTH-1:0] strb;
		logic [1:0] resp;
	} golden_t;

	logic clk;
	logic rst_n;
	axi_lite_pkg::axi_aw_t aw;
	logic aw_valid;
	logic aw_ready;
	axi_lite_pkg::axi_w_t w;
	logic w_valid;
	logic w_ready;
	axi_lite_pkg::axi_b_t b;
	logic b_valid;
	logic b_ready;
	axi_lite_pkg::axi_ar_t ar;
	logic ar_valid;
	logic ar_ready;
	axi_lite_pkg::axi_r_t r;
	logic r_valid;
	logic r_ready;

	golden_t golden[$];
	int num_lines = 0;
	logic [15:0] lfsr_state = 16'd59769;

	axi_lite_regs_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1, "Simulation stopped");
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // Galois form with taps 16 14 13 11
	endfunction

	// Two LFSR bits give a ready delay of 0 to 3 cycles
	task automatic draw_delay(output int cycles);
		cycles = 0;
		repeat (2) begin
			lfsr_state = lfsr_next(lfsr_state);
			cycles = cycles * 2 + int'(lfsr_state[0]);
		end
	endtask

	task automatic check_b(input axi_lite_pkg::axi_b_t got, input axi_lite_pkg::axi_b_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Error at %0d ns: b.resp = %h, expected %h",
				$time, got.resp, exp.resp));
		end
	endtask

	task automatic check_r(input axi_lite_pkg::axi_r_t got, input axi_lite_pkg::axi_r_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Error at %0d ns: r = data %h resp %h, expected data %h resp %h",
				$time, got.data, got.resp, exp.data, exp.resp));
		end
	endtask

	task automatic expect_valid(input logic v, input string name);
		if (v !== 1'b1) begin
			abort_run({name, " dropped before its beat was accepted"});
		end
	endtask

	task automatic load_golden();
		int fd;
		int n;
		logic ok;
		string line;
		string rest;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [31:0] f_strb;
		logic [31:0] f_resp;
		fd = $fopen("verif/axi_lite_golden.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open verif/axi_lite_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line[0] != "#") begin
					rest = line.substr(1, line.len() - 1);
					f_strb = '0;
					if (line[0] == "W") begin
						n = $sscanf(rest, "%h %h %h %h", f_addr, f_data, f_strb, f_resp);
						ok = (n == 4);
					end else if (line[0] == "R") begin
						n = $sscanf(rest, "%h %h %h", f_addr, f_data, f_resp);
						ok = (n == 3);
					end else begin
						ok = 1'b0;
					end
					if (!ok) begin
						abort_run({"Malformed line in the golden file: ", line});
					end else begin
						golden.push_back('{
							is_write: line[0] == "W",
							addr: f_addr[axi_lite_pkg::ADDR_WIDTH-1:0],
							data: f_data,
							strb: f_strb[axi_lite_pkg::STRB_WIDTH-1:0],
							resp: f_resp[1:0]
						});
					end
				end
			end
			$fclose(fd);
			num_lines = golden.size(); // Starts the watchdog
		end
	endtask

	// Starts and ends 2 ns after a rising edge
	task automatic run_write(input golden_t t);
		axi_lite_pkg::axi_b_t exp_b;
		logic aw_take;
		logic w_take;
		int delay;
		exp_b = '{resp: t.resp};
		aw = '{addr: t.addr, prot: 3'b000};
		w = '{data: t.data, strb: t.strb};
		aw_valid = 1'b1;
		w_valid = 1'b1; // W is offered with AW and must wait for WAIT_DATA
		while (aw_valid || w_valid) begin
			@(negedge clk);
			aw_take = aw_valid && aw_ready;
			w_take = w_valid && w_ready;
			@(posedge clk);
			#2;
			if (aw_take) begin
				aw_valid = 1'b0;
			end
			if (w_take) begin
				w_valid = 1'b0;
			end
		end
		@(negedge clk);
		while (!b_valid) begin
			@(negedge clk);
		end
		check_b(b, exp_b);
		draw_delay(delay);
		repeat (delay) begin
			@(negedge clk);
			expect_valid(b_valid, "b_valid");
			check_b(b, exp_b); // Held steady under back-pressure
		end
		@(posedge clk);
		#2;
		b_ready = 1'b1;
		@(negedge clk);
		expect_valid(b_valid, "b_valid");
		check_b(b, exp_b);
		@(posedge clk);
		#2;
		b_ready = 1'b0;
	endtask

	task automatic run_read(input golden_t t);
		axi_lite_pkg::axi_r_t exp_r;
		logic ar_take;
		int delay;
		exp_r = '{data: t.data, resp: t.resp};
		ar = '{addr: t.addr, prot: 3'b000};
		ar_valid = 1'b1;
		while (ar_valid) begin
			@(negedge clk);
			ar_take = ar_valid && ar_ready;
			@(posedge clk);
			#2;
			if (ar_take) begin
				ar_valid = 1'b0;
			end
		end
		@(negedge clk);
		while (!r_valid) begin
			@(negedge clk);
		end
		check_r(r, exp_r);
		draw_delay(delay);
		repeat (delay) begin
			@(negedge clk);
			expect_valid(r_valid, "r_valid");
			check_r(r, exp_r);
		end
		@(posedge clk);
		#2;
		r_ready = 1'b1;
		@(negedge clk);
		expect_valid(r_valid, "r_valid");
		check_r(r, exp_r);
		@(posedge clk);
		#2;
		r_ready = 1'b0;
	endtask

	initial begin
		wait (num_lines > 0);
		repeat (num_lines * 20 + 16) @(posedge clk);
		abort_run("Timeout: the golden transactions did not finish in time");
	end

	initial begin
		rst_n = 1'b0;
		aw = '0;
		aw_valid = 1'b0;
		w = '0;
		w_valid = 1'b0;
		b_ready = 1'b0;
		ar = '0;
		ar_valid = 1'b0;
		r_ready = 1'b0;
		load_golden();
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < num_lines; i++) begin
			if (golden[i].is_write) begin
				run_write(golden[i]);
			end else begin
				run_read(golden[i]);
			end
		end
		@(posedge clk);
		#2;
		if (num_lines > 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run("The golden file held no transactions to run");
		end
	end

endmodule
